// File: src.f
+incdir+test
logic/dcache_cfg_pkg.sv
logic/dcache_ctrl_pkg.sv
logic/dcache_way.sv
logic/dcache_controller.sv
logic/dcache.sv
test/tb_clock.sv
test/tb_mem_model.sv
test/tb_dcache.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_dcache -f src.f

sim_out=$(./obj_dir/Vtb_dcache 2>&1) || true
echo "$sim_out"

if grep -q "TEST PASSED" <<< "$sim_out"
then
  exit 0
fi
exit 1

// File: test/lfsr.svh
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Galois LFSR for test stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam logic [31:0] LFSR_SEED = 32'hee74b4d3;
  localparam logic [31:0] LFSR_TAPS = 32'h80200003;  // x^32 + x^22 + x^2 + x + 1

  // One LFSR step per bit taken
  function automatic logic [31:0] draw_bits(input int n, inout logic [31:0] state);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < n; i++)
    begin
      value[i] = state[0];  // First bit lands in bit 0
      state = {1'b0, state[31:1]} ^ (state[0] ? LFSR_TAPS : 32'h0);
    end
    return value;
  endfunction

// File: test/tb_dcache.sv
module tb_dcache;

  timeunit 1ns;
  timeprecision 1ps;

  `include "lfsr.svh"

  localparam int IDX_W          = 3;
  localparam int N_SETS         = 2**IDX_W;
  localparam int MEM_DEPTH      = 1024;
  localparam int MEM_AW         = 10;
  localparam int PERIOD         = 100;
  localparam int ACCESS_TIMEOUT = 200;
  localparam int FLUSH_TIMEOUT  = 1000;

  logic                  CLK;
  logic                  nRST;
  logic                  dmemREN;
  logic                  dmemWEN;
  logic                  halt;
  logic                  dhit;
  logic                  flushed;
  logic                  dREN;
  logic                  dWEN;
  logic                  dwait;
  dcache_cfg_pkg::word_t dmemaddr;
  dcache_cfg_pkg::word_t dmemstore;
  dcache_cfg_pkg::word_t dmemload;
  dcache_cfg_pkg::word_t dload;
  dcache_cfg_pkg::word_t daddr;
  dcache_cfg_pkg::word_t dstore;

  // Reference cache state
  dcache_cfg_pkg::word_t ref_tag   [N_SETS][2];
  logic                  ref_valid [N_SETS][2];
  logic                  ref_dirty [N_SETS][2];
  dcache_cfg_pkg::word_t ref_data  [N_SETS][2][2];
  logic                  ref_lru   [N_SETS];
  dcache_cfg_pkg::word_t shadow    [MEM_DEPTH];
  int                    hits;
  int                    misses;
  logic [31:0]           lfsr_q = LFSR_SEED;

  tb_clock #(.PERIOD_NS(PERIOD), .RESET_CYCLES(4)) clock_i (.CLK(CLK), .nRST(nRST));

  tb_mem_model #(.DEPTH(MEM_DEPTH)) mem_i (
    .CLK(CLK), .nRST(nRST), .dREN(dREN), .dWEN(dWEN),
    .daddr(daddr), .dstore(dstore), .dload(dload), .dwait(dwait)
  );

  dcache #(.IDX_W(IDX_W)) dcache_i (
    .CLK(CLK), .nRST(nRST), .dmemREN(dmemREN), .dmemWEN(dmemWEN),
    .dmemaddr(dmemaddr), .dmemstore(dmemstore), .halt(halt),
    .dload(dload), .dwait(dwait), .dmemload(dmemload), .dhit(dhit),
    .flushed(flushed), .dREN(dREN), .dWEN(dWEN), .daddr(daddr), .dstore(dstore)
  );

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input dcache_cfg_pkg::word_t actual,
                            input dcache_cfg_pkg::word_t expected);
    assert (actual === expected)
    else
      abort_run($sformatf("MISMATCH time=%0t %s actual=%h expected=%h",
                          $time, name, actual, expected));
  endtask

  task automatic check_bit(input string name, input logic actual, input logic expected);
    assert (actual === expected)
    else
      abort_run($sformatf("MISMATCH time=%0t %s actual=%b expected=%b",
                          $time, name, actual, expected));
  endtask

  function automatic int mem_index(input dcache_cfg_pkg::word_t addr);
    return int'(addr[MEM_AW+1:2]);
  endfunction

  function automatic dcache_cfg_pkg::word_t block_addr(input dcache_cfg_pkg::word_t tag,
                                                       input int set, input int word_sel);
    return (tag << (IDX_W + 3)) | dcache_cfg_pkg::word_t'(set << 3)
           | dcache_cfg_pkg::word_t'(word_sel << 2);
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reference model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic model_access(input logic is_write, input dcache_cfg_pkg::word_t addr,
                              input dcache_cfg_pkg::word_t data, output logic exp_hit,
                              output dcache_cfg_pkg::word_t exp_rdata);
    int                    set;
    int                    off;
    int                    way;
    dcache_cfg_pkg::word_t tag;
    set = int'(addr[IDX_W+2:3]);
    off = int'(addr[2]);
    tag = addr >> (IDX_W + 3);
    way = -1;
    for (int w = 0; w < 2; w++)
      if (ref_valid[set][w] && ref_tag[set][w] == tag)
        way = w;
    exp_hit = (way >= 0);
    if (way < 0)
    begin
      misses++;
      way = int'(ref_lru[set]);
      if (ref_valid[set][way] && ref_dirty[set][way])
        for (int k = 0; k < 2; k++)
          shadow[mem_index(block_addr(ref_tag[set][way], set, k))] = ref_data[set][way][k];
      for (int k = 0; k < 2; k++)
        ref_data[set][way][k] = shadow[mem_index(block_addr(tag, set, k))];
      ref_valid[set][way] = 1'b1;
      ref_dirty[set][way] = 1'b0;
      ref_tag[set][way]   = tag;
    end
    hits++;  // Every access ends in one dhit cycle
    ref_lru[set] = (way == 0);
    if (is_write)
    begin
      ref_data[set][way][off] = data;
      ref_dirty[set][way]     = 1'b1;
    end
    exp_rdata = ref_data[set][way][off];
  endtask

  // Starts and ends on a falling edge
  task automatic run_access(input logic is_write, input dcache_cfg_pkg::word_t addr,
                            input dcache_cfg_pkg::word_t data);
    logic                  exp_hit;
    logic                  first_hit;
    logic                  done;
    int                    cycles;
    dcache_cfg_pkg::word_t exp_rdata;
    model_access(is_write, addr, data, exp_hit, exp_rdata);
    dmemREN   = !is_write;
    dmemWEN   = is_write;
    dmemaddr  = addr;
    dmemstore = is_write ? data : '0;
    done      = 1'b0;
    first_hit = 1'b0;
    cycles    = 0;
    while (!done && cycles < ACCESS_TIMEOUT)
    begin
      #(PERIOD / 4);
      if (cycles == 0)
        first_hit = dhit;
      if (dhit)
      begin
        done = 1'b1;
        if (!is_write)
          check_word("dmemload", dmemload, exp_rdata);
      end
      @(negedge CLK);
      cycles++;
    end
    dmemREN = 1'b0;
    dmemWEN = 1'b0;
    assert (done)
    else
      abort_run($sformatf("No dhit within %0d cycles for address %h", ACCESS_TIMEOUT, addr));
    check_bit("dhit", first_hit, exp_hit);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Directed tests
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic test_read_miss_then_hit();
    run_access(1'b0, 32'h0000_0200, '0);  // Miss and fill
    run_access(1'b0, 32'h0000_0204, '0);
  endtask

  task automatic test_write_hit_readback();
    run_access(1'b0, 32'h0000_0208, '0);
    run_access(1'b1, 32'h0000_0208, 32'hC0DE_1234);
    run_access(1'b0, 32'h0000_0208, '0);
    check_word("mem[0x208]", mem_i.mem[mem_index(32'h208)], 32'h0000_0208 ^ 32'hA5A5_0000);
  endtask

  task automatic test_lru_writeback();
    run_access(1'b1, 32'h0000_0210, 32'h1234_5678);
    run_access(1'b0, 32'h0000_0250, '0);
    run_access(1'b0, 32'h0000_0290, '0);  // Evicts the dirty block
    check_word("mem[0x210]", mem_i.mem[mem_index(32'h210)], 32'h1234_5678);
    run_access(1'b0, 32'h0000_0210, '0);
  endtask

  task automatic test_random_traffic();
    logic [31:0]           is_wr;
    logic [31:0]           off;
    logic [31:0]           set;
    logic [31:0]           tag;
    logic [31:0]           data;
    dcache_cfg_pkg::word_t addr;
    for (int i = 0; i < 200; i++)
    begin
      is_wr = draw_bits(1, lfsr_q);
      off   = draw_bits(1, lfsr_q);
      set   = draw_bits(2, lfsr_q);
      tag   = draw_bits(3, lfsr_q);
      data  = '0;
      if (is_wr[0])
        data = draw_bits(32, lfsr_q);
      addr = block_addr(8 + tag, 4 + int'(set), int'(off));
      run_access(is_wr[0], addr, data);
    end
  endtask

  task automatic test_halt_flush();
    int cycles;
    for (int s = 0; s < N_SETS; s++)
      for (int w = 0; w < 2; w++)
        if (ref_valid[s][w] && ref_dirty[s][w])
          for (int k = 0; k < 2; k++)
            shadow[mem_index(block_addr(ref_tag[s][w], s, k))] = ref_data[s][w][k];
    halt   = 1'b1;
    cycles = 0;
    while (!flushed && cycles < FLUSH_TIMEOUT)
    begin
      @(negedge CLK);
      cycles++;
    end
    assert (flushed)
    else
      abort_run($sformatf("flushed not raised within %0d cycles of halt", FLUSH_TIMEOUT));
    for (int i = 0; i < MEM_DEPTH; i++)
      if (i != mem_index(dcache_cfg_pkg::HIT_COUNT_ADDR))
        check_word($sformatf("mem[%0d]", i), mem_i.mem[i], shadow[i]);
    check_word("mem[0x3100]", mem_i.mem[mem_index(dcache_cfg_pkg::HIT_COUNT_ADDR)],
               dcache_cfg_pkg::word_t'(hits - misses));
    for (int i = 0; i < 20; i++)
    begin
      @(negedge CLK);
      check_bit("flushed", flushed, 1'b1);
    end
  endtask

  initial
  begin
    int n;
    dmemREN   = 1'b0;
    dmemWEN   = 1'b0;
    dmemaddr  = '0;
    dmemstore = '0;
    halt      = 1'b0;
    hits      = 0;
    misses    = 0;
    for (int i = 0; i < MEM_DEPTH; i++)
      shadow[i] = dcache_cfg_pkg::word_t'(i << 2) ^ 32'hA5A5_0000;
    for (int s = 0; s < N_SETS; s++)
    begin
      ref_lru[s] = 1'b0;
      for (int w = 0; w < 2; w++)
      begin
        ref_valid[s][w] = 1'b0;
        ref_dirty[s][w] = 1'b0;
        ref_tag[s][w]   = '0;
      end
    end

    n = 0;
    while (nRST !== 1'b1 && n < 20)
    begin
      @(negedge CLK);
      n++;
    end
    assert (nRST)
    else
      abort_run("Reset was never released");
    @(negedge CLK);
    check_bit("dREN", dREN, 1'b0);
    check_bit("dWEN", dWEN, 1'b0);
    check_bit("dhit", dhit, 1'b0);
    check_bit("flushed", flushed, 1'b0);

    test_read_miss_then_hit();
    test_write_hit_readback();
    test_lru_writeback();
    test_random_traffic();
    test_halt_flush();

    $display("TEST PASSED");
    $finish;
  end

endmodule

// File: test/tb_mem_model.sv
module tb_mem_model #(
  parameter int DEPTH = 1024
) (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  dREN,
  input  logic                  dWEN,
  input  dcache_cfg_pkg::word_t daddr,
  input  dcache_cfg_pkg::word_t dstore,
  output dcache_cfg_pkg::word_t dload,
  output logic                  dwait
);

  timeunit 1ns;
  timeprecision 1ps;

  `include "lfsr.svh"

  localparam int ADDR_W = $clog2(DEPTH);

  dcache_cfg_pkg::word_t mem [DEPTH];

  logic [31:0]       lfsr_q = LFSR_SEED;
  logic              busy;
  logic [1:0]        wait_left;  // Extra wait cycles still to go
  logic              req;
  logic [ADDR_W-1:0] word_idx;

  assign req      = dREN || dWEN;
  assign word_idx = daddr[ADDR_W+1:2];
  assign dload    = mem[word_idx];
  assign dwait    = req && !(busy && (wait_left == 2'd0));

  initial
  begin
    for (int i = 0; i < DEPTH; i++)
      mem[i] = dcache_cfg_pkg::word_t'(i << 2) ^ 32'hA5A5_0000;
  end

  // First request cycle draws 0 to 3 more wait cycles
  always @(posedge CLK or negedge nRST)
  begin
    logic [31:0] draw;
    if (!nRST)
    begin
      busy      <= 1'b0;
      wait_left <= 2'd0;
    end
    else if (req)
    begin
      if (!busy)
      begin
        draw      = draw_bits(2, lfsr_q);
        busy      <= 1'b1;
        wait_left <= draw[1:0];
      end
      else if (wait_left != 2'd0)
        wait_left <= wait_left - 2'd1;
      else
      begin
        busy <= 1'b0;  // Transfer taken this edge
        if (dWEN)
          mem[word_idx] <= dstore;
      end
    end
  end

endmodule

// File: test/tb_clock.sv
module tb_clock #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 4
) (
  output logic CLK,
  output logic nRST
);

  timeunit 1ns;
  timeprecision 1ps;

  initial
  begin
    CLK = 1'b0;
    forever #(PERIOD_NS / 2) CLK = ~CLK;
  end

  // Release on a falling edge, like all other stimulus
  initial
  begin
    nRST = 1'b0;
    repeat (RESET_CYCLES) @(posedge CLK);
    @(negedge CLK);
    nRST = 1'b1;
  end

endmodule

// File: logic/dcache.sv
module dcache #(
  parameter int IDX_W = 3
) (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  dmemREN,
  input  logic                  dmemWEN,
  input  dcache_cfg_pkg::word_t dmemaddr,
  input  dcache_cfg_pkg::word_t dmemstore,
  input  logic                  halt,
  input  dcache_cfg_pkg::word_t dload,
  input  logic                  dwait,
  output dcache_cfg_pkg::word_t dmemload,
  output logic                  dhit,
  output logic                  flushed,
  output logic                  dREN,
  output logic                  dWEN,
  output dcache_cfg_pkg::word_t daddr,
  output dcache_cfg_pkg::word_t dstore
);

  localparam int TAG_W = dcache_cfg_pkg::WORD_W - IDX_W
                       - dcache_cfg_pkg::BLK_OFF_W - dcache_cfg_pkg::BYTE_OFF_W;
  localparam int N_SETS = 2**IDX_W;
  localparam int N_WAYS = dcache_ctrl_pkg::N_WAYS;

  typedef logic [TAG_W-1:0] tag_t;

  tag_t                  req_tag;
  logic [IDX_W-1:0]      req_idx;

  logic [N_WAYS-1:0]     way_hit;
  logic [N_WAYS-1:0]     way_wr_word;
  logic [N_WAYS-1:0]     way_fill_word;
  logic [N_WAYS-1:0]     way_fill_last;
  logic [N_WAYS-1:0]     way_clear_dirty;
  logic [N_WAYS-1:0]     way_victim_dirty;
  dcache_cfg_pkg::word_t way_rd_data     [N_WAYS];
  tag_t                  way_victim_tag  [N_WAYS];
  dcache_cfg_pkg::word_t way_victim_data [N_WAYS];
  dcache_cfg_pkg::word_t way_wr_data;

  // Controller side
  logic                    fill_word;
  logic                    fill_last;
  logic                    fill_sel;
  logic                    clear_dirty;
  logic [IDX_W-1:0]        scan_idx;
  logic                    victim_sel;
  dcache_cfg_pkg::blkoff_t victim_blkoff;
  logic                    victim_dirty;
  tag_t                    victim_tag;
  dcache_cfg_pkg::word_t   victim_data;
  logic                    miss;

  logic [N_SETS-1:0]     lru_q;  // Way to replace next
  dcache_cfg_pkg::word_t hit_count;

  assign req_idx = dmemaddr[dcache_cfg_pkg::BYTE_OFF_W + dcache_cfg_pkg::BLK_OFF_W +: IDX_W];
  assign req_tag = dmemaddr[dcache_cfg_pkg::WORD_W-1 -: TAG_W];

  // Memory busy means the controller has left IDLE
  assign dhit = (|way_hit) && (dmemREN || dmemWEN) && !halt && !flushed && !dREN && !dWEN;

  assign dmemload    = way_hit[1] ? way_rd_data[1] : way_rd_data[0];
  assign way_wr_data = dREN ? dload : dmemstore;  // Fill data or store data

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Ways
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  for (genvar w = 0; w < N_WAYS; w++)
  begin : g_way
    assign way_wr_word[w]     = dhit && dmemWEN && way_hit[w];
    assign way_fill_word[w]   = fill_word && (fill_sel == 1'(w));
    assign way_fill_last[w]   = fill_last && (fill_sel == 1'(w));
    assign way_clear_dirty[w] = clear_dirty && (victim_sel == 1'(w));

    dcache_way #(
      .IDX_W (IDX_W)
    ) way_i (
      .CLK          (CLK),
      .nRST         (nRST),
      .idx          (req_idx),
      .tag          (req_tag),
      .blkoff       (victim_blkoff),  // Request offset while idle
      .wr_word      (way_wr_word[w]),
      .wr_data      (way_wr_data),
      .fill_word    (way_fill_word[w]),
      .fill_last    (way_fill_last[w]),
      .clear_dirty  (way_clear_dirty[w]),
      .scan_idx     (scan_idx),
      .hit          (way_hit[w]),
      .rd_data      (way_rd_data[w]),
      .victim_dirty (way_victim_dirty[w]),
      .victim_tag   (way_victim_tag[w]),
      .victim_data  (way_victim_data[w])
    );
  end

  assign victim_dirty = way_victim_dirty[victim_sel];
  assign victim_tag   = way_victim_tag[victim_sel];
  assign victim_data  = way_victim_data[victim_sel];

  dcache_controller #(
    .IDX_W (IDX_W)
  ) ctrl_i (
    .CLK           (CLK),
    .nRST          (nRST),
    .dmemREN       (dmemREN),
    .dmemWEN       (dmemWEN),
    .dmemaddr      (dmemaddr),
    .halt          (halt),
    .hit           (|way_hit),
    .lru_way       (lru_q[req_idx]),
    .victim_dirty  (victim_dirty),
    .victim_tag    (victim_tag),
    .victim_data   (victim_data),
    .dwait         (dwait),
    .dload         (dload),
    .hit_count     (hit_count),
    .dREN          (dREN),
    .dWEN          (dWEN),
    .daddr         (daddr),
    .dstore        (dstore),
    .fill_word     (fill_word),
    .fill_last     (fill_last),
    .fill_sel      (fill_sel),
    .clear_dirty   (clear_dirty),
    .scan_idx      (scan_idx),
    .victim_sel    (victim_sel),
    .victim_blkoff (victim_blkoff),
    .miss          (miss),
    .flushed       (flushed)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // LRU and hit counter
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
      lru_q <= '0;
    else if (dhit)
      lru_q[req_idx] <= way_hit[0];  // Point at the other way
  end

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
      hit_count <= '0;
    else if (dhit)
      hit_count <= hit_count + 1'b1;
    else if (miss)
      hit_count <= hit_count - 1'b1;  // Once per miss
  end

  // A block lives in one way only
  a_single_way_hit: assert property (@(posedge CLK) disable iff (!nRST)
    !(way_hit[0] && way_hit[1]))
    else $error("both ways hit the same address");

endmodule

// File: logic/dcache_controller.sv
module dcache_controller #(
  parameter int IDX_W = 3
) (
  CLK,
  nRST,
  dmemREN,
  dmemWEN,
  dmemaddr,
  halt,
  hit,
  lru_way,
  victim_dirty,
  victim_tag,
  victim_data,
  dwait,
  dload,
  hit_count,
  dREN,
  dWEN,
  daddr,
  dstore,
  fill_word,
  fill_last,
  fill_sel,
  clear_dirty,
  scan_idx,
  victim_sel,
  victim_blkoff,
  miss,
  flushed
);

  localparam int TAG_W = dcache_cfg_pkg::WORD_W - IDX_W
                       - dcache_cfg_pkg::BLK_OFF_W - dcache_cfg_pkg::BYTE_OFF_W;
  localparam int WAY_W = $clog2(dcache_ctrl_pkg::N_WAYS);
  localparam int CNT_W = IDX_W + WAY_W;

  typedef logic [TAG_W-1:0] tag_t;

  input  logic                    CLK;
  input  logic                    nRST;
  input  logic                    dmemREN;
  input  logic                    dmemWEN;
  input  dcache_cfg_pkg::word_t   dmemaddr;
  input  logic                    halt;
  input  logic                    hit;
  input  logic                    lru_way;
  input  logic                    victim_dirty;
  input  tag_t                    victim_tag;
  input  dcache_cfg_pkg::word_t   victim_data;
  input  logic                    dwait;
  input  dcache_cfg_pkg::word_t   dload;
  input  dcache_cfg_pkg::word_t   hit_count;
  output logic                    dREN;
  output logic                    dWEN;
  output dcache_cfg_pkg::word_t   daddr;
  output dcache_cfg_pkg::word_t   dstore;
  output logic                    fill_word;
  output logic                    fill_last;
  output logic                    fill_sel;
  output logic                    clear_dirty;
  output logic [IDX_W-1:0]        scan_idx;
  output logic                    victim_sel;
  output dcache_cfg_pkg::blkoff_t victim_blkoff;
  output logic                    miss;
  output logic                    flushed;

  dcache_ctrl_pkg::dcache_state_t state;
  dcache_ctrl_pkg::dcache_state_t next_state;

  logic [CNT_W-1:0]        flush_cnt;  // {set, way}
  logic [IDX_W-1:0]        flush_set;
  logic [WAY_W-1:0]        flush_way;
  logic                    flush_step;
  logic                    scan_last;
  logic                    flushing;
  logic                    req;
  tag_t                    req_tag;
  logic [IDX_W-1:0]        req_idx;
  dcache_cfg_pkg::blkoff_t req_off;
  dcache_cfg_pkg::blkoff_t xfer_off;

  // Request address fields
  assign req_off = dmemaddr[dcache_cfg_pkg::BYTE_OFF_W +: dcache_cfg_pkg::BLK_OFF_W];
  assign req_idx = dmemaddr[dcache_cfg_pkg::BYTE_OFF_W + dcache_cfg_pkg::BLK_OFF_W +: IDX_W];
  assign req_tag = dmemaddr[dcache_cfg_pkg::WORD_W-1 -: TAG_W];
  assign req     = dmemREN || dmemWEN;

  assign miss = (state == dcache_ctrl_pkg::IDLE) && req && !hit && !halt;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Flush walk
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign flushing = state inside {dcache_ctrl_pkg::FLUSH_SCAN,
                                  dcache_ctrl_pkg::FLUSH_WB0,
                                  dcache_ctrl_pkg::FLUSH_WB1};

  assign flush_way = flush_cnt[WAY_W-1:0];
  assign flush_set = flush_cnt[CNT_W-1:WAY_W];
  assign scan_last = &flush_cnt;

  // Move on past a clean entry or a finished write-back
  assign flush_step = ((state == dcache_ctrl_pkg::FLUSH_SCAN) && !victim_dirty) ||
                      ((state == dcache_ctrl_pkg::FLUSH_WB1) && !dwait);

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
      flush_cnt <= '0;
    else if (flush_step)
      flush_cnt <= flush_cnt + 1'b1;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // FSM
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
      state <= dcache_ctrl_pkg::IDLE;
    else
      state <= next_state;
  end

  always_comb
  begin
    next_state = state;
    case (state)
      dcache_ctrl_pkg::IDLE:
        if (halt)
          next_state = dcache_ctrl_pkg::FLUSH_SCAN;
        else if (miss)
          next_state = victim_dirty ? dcache_ctrl_pkg::WB0 : dcache_ctrl_pkg::FETCH0;
      dcache_ctrl_pkg::WB0:
        if (!dwait)
          next_state = dcache_ctrl_pkg::WB1;
      dcache_ctrl_pkg::WB1:
        if (!dwait)
          next_state = dcache_ctrl_pkg::FETCH0;
      dcache_ctrl_pkg::FETCH0:
        if (!dwait)
          next_state = dcache_ctrl_pkg::FETCH1;
      dcache_ctrl_pkg::FETCH1:
        if (!dwait)
          next_state = dcache_ctrl_pkg::IDLE;  // Request hits next cycle
      dcache_ctrl_pkg::FLUSH_SCAN:
        if (victim_dirty)
          next_state = dcache_ctrl_pkg::FLUSH_WB0;
        else if (scan_last)
          next_state = dcache_ctrl_pkg::STORE_COUNT;
      dcache_ctrl_pkg::FLUSH_WB0:
        if (!dwait)
          next_state = dcache_ctrl_pkg::FLUSH_WB1;
      dcache_ctrl_pkg::FLUSH_WB1:
        if (!dwait)
          next_state = scan_last ? dcache_ctrl_pkg::STORE_COUNT : dcache_ctrl_pkg::FLUSH_SCAN;
      dcache_ctrl_pkg::STORE_COUNT:
        if (!dwait)
          next_state = dcache_ctrl_pkg::DONE;
      dcache_ctrl_pkg::DONE:
        next_state = dcache_ctrl_pkg::DONE;  // Until reset
      default:
        next_state = dcache_ctrl_pkg::IDLE;
    endcase
  end

  // Word of the block being moved
  always_comb
  begin
    case (state)
      dcache_ctrl_pkg::IDLE:      xfer_off = req_off;
      dcache_ctrl_pkg::WB1:       xfer_off = 1'b1;
      dcache_ctrl_pkg::FETCH1:    xfer_off = 1'b1;
      dcache_ctrl_pkg::FLUSH_WB1: xfer_off = 1'b1;
      default:                    xfer_off = 1'b0;
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Memory port and way controls
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign dREN = state inside {dcache_ctrl_pkg::FETCH0, dcache_ctrl_pkg::FETCH1};
  assign dWEN = state inside {dcache_ctrl_pkg::WB0, dcache_ctrl_pkg::WB1,
                              dcache_ctrl_pkg::FLUSH_WB0, dcache_ctrl_pkg::FLUSH_WB1,
                              dcache_ctrl_pkg::STORE_COUNT};

  always_comb
  begin
    if (dREN)
      daddr = {req_tag, req_idx, xfer_off, {dcache_cfg_pkg::BYTE_OFF_W{1'b0}}};
    else if (state == dcache_ctrl_pkg::STORE_COUNT)
      daddr = dcache_cfg_pkg::HIT_COUNT_ADDR;
    else
      daddr = {victim_tag, scan_idx, xfer_off, {dcache_cfg_pkg::BYTE_OFF_W{1'b0}}};
  end

  assign dstore = (state == dcache_ctrl_pkg::STORE_COUNT) ? hit_count : victim_data;

  // Fetched words go straight into the victim way
  assign fill_word   = dREN && !dwait;
  assign fill_last   = (state == dcache_ctrl_pkg::FETCH1) && !dwait;
  assign fill_sel    = lru_way;
  assign clear_dirty = (state == dcache_ctrl_pkg::FLUSH_WB1) && !dwait;

  assign scan_idx      = flushing ? flush_set : req_idx;
  assign victim_sel    = flushing ? flush_way : lru_way;
  assign victim_blkoff = xfer_off;

  assign flushed = (state == dcache_ctrl_pkg::DONE);

  // A request stays put until the cycle with dwait low
  a_req_hold: assert property (@(posedge CLK) disable iff (!nRST)
    (dREN || dWEN) && dwait |=> $stable(dREN) && $stable(dWEN) && $stable(daddr))
    else $error("memory request changed while dwait was high");

  // Only dirty blocks are written back
  a_wb_dirty: assert property (@(posedge CLK) disable iff (!nRST)
    state inside {dcache_ctrl_pkg::WB0, dcache_ctrl_pkg::WB1,
                  dcache_ctrl_pkg::FLUSH_WB0, dcache_ctrl_pkg::FLUSH_WB1} |-> victim_dirty)
    else $error("write-back of a block that is not dirty");

endmodule

// File: logic/dcache_way.sv
module dcache_way #(
  parameter int IDX_W = 3
) (
  CLK,
  nRST,
  idx,
  tag,
  blkoff,
  wr_word,
  wr_data,
  fill_word,
  fill_last,
  clear_dirty,
  scan_idx,
  hit,
  rd_data,
  victim_dirty,
  victim_tag,
  victim_data
);

  localparam int TAG_W = dcache_cfg_pkg::WORD_W - IDX_W
                       - dcache_cfg_pkg::BLK_OFF_W - dcache_cfg_pkg::BYTE_OFF_W;
  localparam int N_SETS = 2**IDX_W;

  typedef logic [TAG_W-1:0] tag_t;

  input  logic                    CLK;
  input  logic                    nRST;
  input  logic [IDX_W-1:0]        idx;
  input  tag_t                    tag;
  input  dcache_cfg_pkg::blkoff_t blkoff;
  input  logic                    wr_word;
  input  dcache_cfg_pkg::word_t   wr_data;
  input  logic                    fill_word;
  input  logic                    fill_last;
  input  logic                    clear_dirty;
  input  logic [IDX_W-1:0]        scan_idx;
  output logic                    hit;
  output dcache_cfg_pkg::word_t   rd_data;
  output logic                    victim_dirty;
  output tag_t                    victim_tag;
  output dcache_cfg_pkg::word_t   victim_data;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Storage
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  tag_t                  tag_q   [N_SETS];
  logic [N_SETS-1:0]     valid_q;
  logic [N_SETS-1:0]     dirty_q;
  dcache_cfg_pkg::word_t data_q  [N_SETS][dcache_cfg_pkg::BLK_WORDS];

  // Lookup on the request index
  assign hit     = valid_q[idx] && (tag_q[idx] == tag);
  assign rd_data = data_q[idx][blkoff];

  // Victim side follows scan_idx, which is the flush set during a flush
  assign victim_dirty = dirty_q[scan_idx];
  assign victim_tag   = tag_q[scan_idx];
  assign victim_data  = data_q[scan_idx][blkoff];

  always_ff @(posedge CLK)
  begin
    if (wr_word || fill_word)
      data_q[idx][blkoff] <= wr_data;
    if (fill_last)
      tag_q[idx] <= tag;  // Tag lands with the second word
  end

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      valid_q <= '0;
      dirty_q <= '0;
    end
    else
    begin
      if (fill_last)
      begin
        valid_q[idx] <= 1'b1;
        dirty_q[idx] <= 1'b0;  // Fresh copy of memory
      end
      else if (wr_word)
        dirty_q[idx] <= 1'b1;
      if (clear_dirty)
        dirty_q[scan_idx] <= 1'b0;
    end
  end

  // Store hits and fills come from different sources
  a_wr_fill_excl: assert property (@(posedge CLK) disable iff (!nRST)
    !(wr_word && fill_word))
    else $error("way written by store and fill in one cycle");

endmodule

// File: logic/dcache_ctrl_pkg.sv
package dcache_ctrl_pkg;

  // Controller FSM states
  typedef enum logic [3:0] {
    IDLE,
    WB0,          // Write back victim word 0
    WB1,
    FETCH0,       // Fill from memory
    FETCH1,
    FLUSH_SCAN,   // Walk sets and ways on halt
    FLUSH_WB0,
    FLUSH_WB1,
    STORE_COUNT,  // Write hit count to memory
    DONE
  } dcache_state_t;

  // Ways walked per set during flush
  localparam int N_WAYS = 2;

endpackage

// File: logic/dcache_cfg_pkg.sv
package dcache_cfg_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Word and address layout
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int WORD_W = 32;

  // Data, addresses and the hit count
  typedef logic [WORD_W-1:0] word_t;

  localparam int BYTE_OFF_W = 2;  // Ignored low address bits
  localparam int BLK_OFF_W  = 1;  // Word within block at bit 2

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Block geometry
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int BLK_WORDS = 2;

  typedef logic [BLK_OFF_W-1:0] blkoff_t;

  // Counter dump location at the end of a flush
  localparam word_t HIT_COUNT_ADDR = 32'h00003100;

endpackage
